//--- config_regs.sv
`timescale 1ns/1ns
`include "memsched_macros.svh"

module config_regs (
    input  logic                                       aclk,
    input  logic                                       reset,
    input  logic                                       cfg_we,
    input  logic [2:0]                                 cfg_addr,
    input  logic [`MS_REG_W-1:0]                       cfg_wdata,
    output memsched_pkg::sched_mode_t                  mode,
    output memsched_pkg::sched_param_u [`MS_NUM_Q-1:0] params,
    output logic [`MS_NUM_Q-1:0]                       param_written
);

    logic [`MS_NUM_Q-1:0] param_hit;

    // Address 0 is the mode, queue q sits at q + 1
    always_comb
    begin
        for (int q = 0; q < `MS_NUM_Q; q++)
            param_hit[q] = cfg_we && (cfg_addr == 3'(q + 1));
    end

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            mode          <= memsched_pkg::mode_fp;
            param_written <= '0;
            for (int q = 0; q < `MS_NUM_Q; q++)
                params[q].deadline <= `MS_REG_W'(16);
        end
        else
        begin
            // Pulse lines up with the cycle the new value is visible
            param_written <= param_hit;
            if (cfg_we && cfg_addr == 3'd0)
                mode <= memsched_pkg::sched_mode_t'(cfg_wdata[0]);
            for (int q = 0; q < `MS_NUM_Q; q++)
            begin
                if (param_hit[q])
                    params[q].deadline <= cfg_wdata;
            end
        end
    end

endmodule

//--- core_queues.sv
`timescale 1ns/1ns
`include "memsched_macros.svh"

module core_queues (
    input  logic                                         aclk,
    input  logic                                         reset,
    input  memsched_pkg::mem_packet_t                    packet0,
    input  logic                                         pkt_valid0,
    output logic                                         pkt_accept0,
    input  memsched_pkg::mem_packet_t                    packet1,
    input  logic                                         pkt_valid1,
    output logic                                         pkt_accept1,
    input  logic                                         pop,
    input  logic [$clog2(`MS_NUM_Q)-1:0]                 pop_index,
    output memsched_pkg::mem_packet_t [`MS_NUM_Q-1:0]    q_heads,
    output logic [`MS_NUM_Q-1:0]                         q_nonempty
);

    localparam int PTR_W = $clog2(`MS_Q_DEPTH);
    localparam int CNT_W = $clog2(`MS_Q_DEPTH + 1);

    memsched_pkg::mem_packet_t mem [`MS_NUM_Q][`MS_Q_DEPTH];
    logic [PTR_W-1:0]          wr_ptr [`MS_NUM_Q];
    logic [PTR_W-1:0]          rd_ptr [`MS_NUM_Q];
    logic [CNT_W-1:0]          count [`MS_NUM_Q];
    logic [`MS_NUM_Q-1:0]      full;
    logic [`MS_NUM_Q-1:0]      push;
    logic [`MS_NUM_Q-1:0]      pull;
    logic                      wr_en;
    memsched_pkg::mem_packet_t wr_pkt;

    //////////////////////////////
    // Admission, port 0 first
    //////////////////////////////

    assign pkt_accept0 = pkt_valid0 && !full[packet0.core_id];
    // Port 1 only gets the write slot when port 0 does not use it
    assign pkt_accept1 = pkt_valid1 && !pkt_accept0 && !full[packet1.core_id];

    assign wr_en  = pkt_accept0 || pkt_accept1;
    assign wr_pkt = pkt_accept0 ? packet0 : packet1;

    always_comb
    begin
        for (int q = 0; q < `MS_NUM_Q; q++)
        begin
            full[q]       = (count[q] == CNT_W'(`MS_Q_DEPTH));
            push[q]       = wr_en && (wr_pkt.core_id == q);
            pull[q]       = pop && (pop_index == q);
            q_nonempty[q] = (count[q] != '0);
            q_heads[q]    = mem[q][rd_ptr[q]];
        end
    end

    //////////////////////////////
    // Storage and pointers
    //////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (wr_en)
            mem[wr_pkt.core_id][wr_ptr[wr_pkt.core_id]] <= wr_pkt;
    end

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            for (int q = 0; q < `MS_NUM_Q; q++)
            begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
                count[q]  <= '0;
            end
        end
        else
        begin
            for (int q = 0; q < `MS_NUM_Q; q++)
            begin
                if (push[q])
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                if (pull[q])
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                count[q] <= count[q] + CNT_W'(push[q]) - CNT_W'(pull[q]);
            end
        end
    end

endmodule

//--- deadline_scheduler.sv
`timescale 1ns/1ns
`include "memsched_macros.svh"

module deadline_scheduler (
    input  logic                                       aclk,
    input  logic                                       reset,
    input  memsched_pkg::sched_mode_t                  mode,
    input  memsched_pkg::sched_param_u [`MS_NUM_Q-1:0] params,
    input  logic [`MS_NUM_Q-1:0]                       param_written,
    input  logic [`MS_NUM_Q-1:0]                       q_nonempty,
    input  logic                                       ser_ready,
    output logic                                       pop,
    output logic [$clog2(`MS_NUM_Q)-1:0]               pop_index
);

    localparam int IDX_W = $clog2(`MS_NUM_Q);

    logic [`MS_REG_W-1:0] counter [`MS_NUM_Q];
    logic [`MS_REG_W-1:0] cand_key;
    logic [`MS_REG_W-1:0] best_key;
    logic [IDX_W-1:0]     best_idx;
    logic                 best_found;

    //////////////////////////////
    // Per-queue deadline counters
    //////////////////////////////

    always_ff @(posedge aclk)
    begin
        for (int q = 0; q < `MS_NUM_Q; q++)
        begin
            if (reset || param_written[q] || (pop && pop_index == q))
                counter[q] <= params[q].deadline;
            else if (counter[q] != '0)
                counter[q] <= counter[q] - 1'b1;
        end
    end

    // Smallest key among non-empty queues, strict compare keeps the lowest index on ties
    always_comb
    begin
        best_found = 1'b0;
        best_idx   = '0;
        best_key   = '0;
        for (int q = 0; q < `MS_NUM_Q; q++)
        begin
            if (mode == memsched_pkg::mode_edf)
                cand_key = counter[q];
            else
                cand_key = {{(`MS_REG_W-4){1'b0}}, params[q].fp.prio};
            if (q_nonempty[q] && (!best_found || cand_key < best_key))
            begin
                best_found = 1'b1;
                best_idx   = IDX_W'(q);
                best_key   = cand_key;
            end
        end
    end

    // One grant per cycle, only into an empty serializer
    assign pop       = ser_ready && best_found;
    assign pop_index = best_idx;

endmodule

//--- memsched_macros.svh
`ifndef MEMSCHED_MACROS_SVH
`define MEMSCHED_MACROS_SVH

// AXI read channel widths
`define MS_ADDR_W   40
`define MS_ID_W     16
`define MS_DATA_W   128

// Queue geometry, one queue per core
`define MS_NUM_Q    4
`define MS_Q_DEPTH  16

// Address bits holding the core id
`define MS_CORE_HI  15
`define MS_CORE_LO  14

// Configuration register width
`define MS_REG_W    32

`endif

//--- memsched_pkg.sv
`include "memsched_macros.svh"

package memsched_pkg;

    //////////////////////////////
    // Request and packet types
    //////////////////////////////

    // One AXI read request as seen on an AR channel
    typedef struct packed {
        logic [`MS_ADDR_W-1:0] addr;
        logic [`MS_ID_W-1:0]   id;
        logic [7:0]            len;
    } ar_req_t;

    // Request waiting in a core queue
    typedef struct packed {
        ar_req_t                          req;
        logic [`MS_CORE_HI-`MS_CORE_LO:0] core_id;
        logic                             src_port;
    } mem_packet_t;

    //////////////////////////////
    // Scheduling configuration
    //////////////////////////////

    typedef enum logic {
        mode_fp  = 1'b0,
        mode_edf = 1'b1
    } sched_mode_t;

    // Priority view, lower value wins
    typedef struct packed {
        logic [`MS_REG_W-5:0] rsvd;
        logic [3:0]           prio;
    } fp_param_t;

    // Same queue register, decoded by the active mode
    typedef union packed {
        logic [`MS_REG_W-1:0] deadline;
        fp_param_t            fp;
    } sched_param_u;

endpackage

//--- memsched_sva.sv
`timescale 1ns/1ns
`include "memsched_macros.svh"

module memsched_sva (
    input logic                  aclk,
    input logic                  reset,
    input memsched_pkg::ar_req_t m_ar,
    input logic                  m_arvalid,
    input logic                  m_arready,
    input logic                  s0_arready,
    input logic                  s1_arready,
    input logic                  m_rvalid,
    input logic [`MS_ID_W-1:0]   m_rid,
    input logic [`MS_DATA_W-1:0] m_rdata,
    input logic                  m_rlast,
    input logic                  m_rready,
    input logic                  s0_rvalid,
    input logic [`MS_ID_W-1:0]   s0_rid,
    input logic [`MS_DATA_W-1:0] s0_rdata,
    input logic                  s0_rlast,
    input logic                  s0_rready,
    input logic                  s1_rvalid,
    input logic [`MS_ID_W-1:0]   s1_rid,
    input logic [`MS_DATA_W-1:0] s1_rdata,
    input logic                  s1_rlast,
    input logic                  s1_rready
);

    localparam int TAG = `MS_ID_W - 1;

    int fail_count;

    initial
    begin
        fail_count = 0;
    end

    // Reset leaves the master idle and both slave ports ready
    reset_state: assert property (@(posedge aclk)
        reset |=> !m_arvalid && s0_arready && s1_arready)
    else
    begin
        $error("master AR not idle or slave AR not ready after reset");
        fail_count++;
    end

    // A stalled master request keeps valid and payload
    ar_hold: assert property (@(posedge aclk) disable iff (reset)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_ar))
    else
    begin
        $error("m_arvalid or m_ar changed before the master handshake");
        fail_count++;
    end

    route_port1: assert property (@(posedge aclk) disable iff (reset)
        m_rvalid && m_rid[TAG] |-> s1_rvalid && !s0_rvalid
            && s1_rid == {1'b0, m_rid[TAG-1:0]} && s1_rdata == m_rdata
            && s1_rlast == m_rlast && m_rready == s1_rready)
    else
    begin
        $error("read response with tag 1 not routed to port 1");
        fail_count++;
    end

    route_port0: assert property (@(posedge aclk) disable iff (reset)
        m_rvalid && !m_rid[TAG] |-> s0_rvalid && !s1_rvalid
            && s0_rid == {1'b0, m_rid[TAG-1:0]} && s0_rdata == m_rdata
            && s0_rlast == m_rlast && m_rready == s0_rready)
    else
    begin
        $error("read response with tag 0 not routed to port 0");
        fail_count++;
    end

endmodule

bind memsched_top memsched_sva i_sva (
    .aclk(aclk), .reset(reset),
    .m_ar(m_ar), .m_arvalid(m_arvalid), .m_arready(m_arready),
    .s0_arready(s0_arready), .s1_arready(s1_arready),
    .m_rvalid(m_rvalid), .m_rid(m_rid), .m_rdata(m_rdata),
    .m_rlast(m_rlast), .m_rready(m_rready),
    .s0_rvalid(s0_rvalid), .s0_rid(s0_rid), .s0_rdata(s0_rdata),
    .s0_rlast(s0_rlast), .s0_rready(s0_rready),
    .s1_rvalid(s1_rvalid), .s1_rid(s1_rid), .s1_rdata(s1_rdata),
    .s1_rlast(s1_rlast), .s1_rready(s1_rready)
);

//--- memsched_top.sv
`timescale 1ns/1ns
`include "memsched_macros.svh"

module memsched_top (
    input  logic                  aclk,
    input  logic                  reset,
    // Slave port 0
    input  memsched_pkg::ar_req_t s0_ar,
    input  logic                  s0_arvalid,
    output logic                  s0_arready,
    output logic                  s0_rvalid,
    output logic [`MS_ID_W-1:0]   s0_rid,
    output logic [`MS_DATA_W-1:0] s0_rdata,
    output logic                  s0_rlast,
    input  logic                  s0_rready,
    // Slave port 1
    input  memsched_pkg::ar_req_t s1_ar,
    input  logic                  s1_arvalid,
    output logic                  s1_arready,
    output logic                  s1_rvalid,
    output logic [`MS_ID_W-1:0]   s1_rid,
    output logic [`MS_DATA_W-1:0] s1_rdata,
    output logic                  s1_rlast,
    input  logic                  s1_rready,
    // Master port
    output memsched_pkg::ar_req_t m_ar,
    output logic                  m_arvalid,
    input  logic                  m_arready,
    input  logic                  m_rvalid,
    input  logic [`MS_ID_W-1:0]   m_rid,
    input  logic [`MS_DATA_W-1:0] m_rdata,
    input  logic                  m_rlast,
    output logic                  m_rready,
    // Configuration write port
    input  logic                  cfg_we,
    input  logic [2:0]            cfg_addr,
    input  logic [`MS_REG_W-1:0]  cfg_wdata
);

    memsched_pkg::mem_packet_t                    pkt0;
    memsched_pkg::mem_packet_t                    pkt1;
    logic                                         pkt_valid0;
    logic                                         pkt_valid1;
    logic                                         pkt_accept0;
    logic                                         pkt_accept1;
    memsched_pkg::mem_packet_t [`MS_NUM_Q-1:0]    q_heads;
    logic [`MS_NUM_Q-1:0]                         q_nonempty;
    logic                                         pop;
    logic [$clog2(`MS_NUM_Q)-1:0]                 pop_index;
    logic                                         ser_ready;
    memsched_pkg::sched_mode_t                    mode;
    memsched_pkg::sched_param_u [`MS_NUM_Q-1:0]   params;
    logic [`MS_NUM_Q-1:0]                         param_written;

    //////////////////////////////
    // Request path
    //////////////////////////////

    request_packetizer #(.source_port(1'b0)) i_pkt0 (
        .aclk(aclk), .reset(reset),
        .ar(s0_ar), .arvalid(s0_arvalid), .arready(s0_arready),
        .pkt_accept(pkt_accept0), .packet(pkt0), .pkt_valid(pkt_valid0)
    );

    request_packetizer #(.source_port(1'b1)) i_pkt1 (
        .aclk(aclk), .reset(reset),
        .ar(s1_ar), .arvalid(s1_arvalid), .arready(s1_arready),
        .pkt_accept(pkt_accept1), .packet(pkt1), .pkt_valid(pkt_valid1)
    );

    core_queues i_queues (
        .aclk(aclk), .reset(reset),
        .packet0(pkt0), .pkt_valid0(pkt_valid0), .pkt_accept0(pkt_accept0),
        .packet1(pkt1), .pkt_valid1(pkt_valid1), .pkt_accept1(pkt_accept1),
        .pop(pop), .pop_index(pop_index),
        .q_heads(q_heads), .q_nonempty(q_nonempty)
    );

    config_regs i_cfg (
        .aclk(aclk), .reset(reset),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .mode(mode), .params(params), .param_written(param_written)
    );

    deadline_scheduler i_sched (
        .aclk(aclk), .reset(reset),
        .mode(mode), .params(params), .param_written(param_written),
        .q_nonempty(q_nonempty), .ser_ready(ser_ready),
        .pop(pop), .pop_index(pop_index)
    );

    request_serializer i_ser (
        .aclk(aclk), .reset(reset),
        .pop(pop), .pop_index(pop_index), .q_heads(q_heads),
        .ser_ready(ser_ready),
        .m_ar(m_ar), .m_arvalid(m_arvalid), .m_arready(m_arready)
    );

    //////////////////////////////
    // Response path
    //////////////////////////////

    read_response_router i_router (
        .m_rvalid(m_rvalid), .m_rid(m_rid), .m_rdata(m_rdata),
        .m_rlast(m_rlast), .m_rready(m_rready),
        .s0_rvalid(s0_rvalid), .s0_rid(s0_rid), .s0_rdata(s0_rdata),
        .s0_rlast(s0_rlast), .s0_rready(s0_rready),
        .s1_rvalid(s1_rvalid), .s1_rid(s1_rid), .s1_rdata(s1_rdata),
        .s1_rlast(s1_rlast), .s1_rready(s1_rready)
    );

endmodule

//--- read_response_router.sv
`timescale 1ns/1ns
`include "memsched_macros.svh"

module read_response_router (
    input  logic                  m_rvalid,
    input  logic [`MS_ID_W-1:0]   m_rid,
    input  logic [`MS_DATA_W-1:0] m_rdata,
    input  logic                  m_rlast,
    output logic                  m_rready,
    output logic                  s0_rvalid,
    output logic [`MS_ID_W-1:0]   s0_rid,
    output logic [`MS_DATA_W-1:0] s0_rdata,
    output logic                  s0_rlast,
    input  logic                  s0_rready,
    output logic                  s1_rvalid,
    output logic [`MS_ID_W-1:0]   s1_rid,
    output logic [`MS_DATA_W-1:0] s1_rdata,
    output logic                  s1_rlast,
    input  logic                  s1_rready
);

    logic [`MS_ID_W-1:0] plain_id;

    // Strip the port tag before handing the ID back
    assign plain_id = {1'b0, m_rid[`MS_ID_W-2:0]};

    always_comb
    begin
        s0_rvalid = 1'b0;
        s0_rid    = '0;
        s0_rdata  = '0;
        s0_rlast  = 1'b0;
        s1_rvalid = 1'b0;
        s1_rid    = '0;
        s1_rdata  = '0;
        s1_rlast  = 1'b0;
        if (m_rid[`MS_ID_W-1])
        begin
            s1_rvalid = m_rvalid;
            s1_rid    = plain_id;
            s1_rdata  = m_rdata;
            s1_rlast  = m_rlast;
            m_rready  = s1_rready;
        end
        else
        begin
            s0_rvalid = m_rvalid;
            s0_rid    = plain_id;
            s0_rdata  = m_rdata;
            s0_rlast  = m_rlast;
            m_rready  = s0_rready;
        end
    end

endmodule

//--- request_packetizer.sv
`timescale 1ns/1ns
`include "memsched_macros.svh"

module request_packetizer #(
    parameter bit source_port = 1'b0
) (
    input  logic                      aclk,
    input  logic                      reset,
    input  memsched_pkg::ar_req_t     ar,
    input  logic                      arvalid,
    output logic                      arready,
    input  logic                      pkt_accept,
    output memsched_pkg::mem_packet_t packet,
    output logic                      pkt_valid
);

    logic                      full;
    memsched_pkg::mem_packet_t pkt_q;

    // Holding register occupancy
    always_ff @(posedge aclk)
    begin
        if (reset)
            full <= 1'b0;
        else if (arvalid && arready)
            full <= 1'b1;
        else if (pkt_accept)
            full <= 1'b0;
    end

    // Capture the request and tag it with core id and port
    always_ff @(posedge aclk)
    begin
        if (arvalid && arready)
        begin
            pkt_q.req      <= ar;
            pkt_q.core_id  <= ar.addr[`MS_CORE_HI:`MS_CORE_LO];
            pkt_q.src_port <= source_port;
        end
    end

    assign arready   = !full;
    assign pkt_valid = full;
    assign packet    = pkt_q;

endmodule

//--- request_serializer.sv
`timescale 1ns/1ns
`include "memsched_macros.svh"

module request_serializer (
    input  logic                                      aclk,
    input  logic                                      reset,
    input  logic                                      pop,
    input  logic [$clog2(`MS_NUM_Q)-1:0]              pop_index,
    input  memsched_pkg::mem_packet_t [`MS_NUM_Q-1:0] q_heads,
    output logic                                      ser_ready,
    output memsched_pkg::ar_req_t                     m_ar,
    output logic                                      m_arvalid,
    input  logic                                      m_arready
);

    memsched_pkg::mem_packet_t head;
    memsched_pkg::ar_req_t     issue_req;

    // Top ID bit carries the source port so the response can find its way back
    always_comb
    begin
        head                       = q_heads[pop_index];
        issue_req                  = head.req;
        issue_req.id[`MS_ID_W-1]   = head.src_port;
    end

    always_ff @(posedge aclk)
    begin
        if (reset)
            m_arvalid <= 1'b0;
        else if (pop)
            m_arvalid <= 1'b1;
        else if (m_arready)
            m_arvalid <= 1'b0;
    end

    // Payload stays put until the master handshake
    always_ff @(posedge aclk)
    begin
        if (pop)
            m_ar <= issue_req;
    end

    assign ser_ready = !m_arvalid;

endmodule

//--- tb.f
+incdir+.
memsched_pkg.sv
request_packetizer.sv
core_queues.sv
config_regs.sv
deadline_scheduler.sv
request_serializer.sv
read_response_router.sv
memsched_top.sv
memsched_sva.sv
tb_memsched.sv

//--- tb_memsched.sv
`timescale 1ns/1ns
`include "memsched_macros.svh"

module tb_memsched;

    localparam int SEED_INIT   = 32'h56011035;
    localparam int WAIT_LIMIT  = 400;
    localparam int RAND_REQS   = 80;
    localparam int RAND_CYCLES = 3000;
    localparam int TAG         = `MS_ID_W - 1;

    logic                  aclk;
    logic                  reset;
    memsched_pkg::ar_req_t s0_ar;
    logic                  s0_arvalid;
    logic                  s0_arready;
    logic                  s0_rvalid;
    logic [`MS_ID_W-1:0]   s0_rid;
    logic [`MS_DATA_W-1:0] s0_rdata;
    logic                  s0_rlast;
    logic                  s0_rready;
    memsched_pkg::ar_req_t s1_ar;
    logic                  s1_arvalid;
    logic                  s1_arready;
    logic                  s1_rvalid;
    logic [`MS_ID_W-1:0]   s1_rid;
    logic [`MS_DATA_W-1:0] s1_rdata;
    logic                  s1_rlast;
    logic                  s1_rready;
    memsched_pkg::ar_req_t m_ar;
    logic                  m_arvalid;
    logic                  m_arready;
    logic                  m_rvalid;
    logic [`MS_ID_W-1:0]   m_rid;
    logic [`MS_DATA_W-1:0] m_rdata;
    logic                  m_rlast;
    logic                  m_rready;
    logic                  cfg_we;
    logic [2:0]            cfg_addr;
    logic [`MS_REG_W-1:0]  cfg_wdata;

    int                      errors;
    integer                  seed;
    logic [`MS_CORE_LO-1:0]  serial;
    memsched_pkg::ar_req_t   sent_q [$];
    int                      sent_port [$];
    memsched_pkg::ar_req_t   issued_q [$];

    memsched_top i_dut (.*);

    initial
    begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // Handshake log on both sides
    always @(posedge aclk)
    begin
        if (!reset && s0_arvalid && s0_arready)
        begin
            sent_q.push_back(s0_ar);
            sent_port.push_back(0);
        end
        if (!reset && s1_arvalid && s1_arready)
        begin
            sent_q.push_back(s1_ar);
            sent_port.push_back(1);
        end
        if (!reset && m_arvalid && m_arready)
            issued_q.push_back(m_ar);
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic next_cycle();
        @(posedge aclk);
        #10;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Unique address per request from a serial number below the core id
    function automatic memsched_pkg::ar_req_t make_req(input logic [1:0] core);
        memsched_pkg::ar_req_t r;
        logic [31:0]           tmp;
        tmp    = $random(seed);
        r.addr = `MS_ADDR_W'({tmp, tmp});
        r.addr[`MS_CORE_HI:`MS_CORE_LO] = core;
        r.addr[`MS_CORE_LO-1:0] = serial;
        r.id   = {1'b0, tmp[TAG+15:16]};
        r.len  = tmp[31:24];
        serial = serial + 1'b1;
        return r;
    endfunction

    task automatic cfg_write(input logic [2:0] addr, input logic [31:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        next_cycle();
        cfg_we    = 1'b0;
    endtask

    task automatic send_req(input int port, input memsched_pkg::ar_req_t req);
        int   waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        if (port == 0)
        begin
            s0_ar      = req;
            s0_arvalid = 1'b1;
        end
        else
        begin
            s1_ar      = req;
            s1_arvalid = 1'b1;
        end
        while (!done && waited < WAIT_LIMIT)
        begin
            @(posedge aclk);
            done = (port == 0) ? s0_arready : s1_arready;
            #10;
            waited++;
        end
        s0_arvalid = 1'b0;
        s1_arvalid = 1'b0;
        if (!done)
        begin
            errors++;
            $display("ERROR at %0t: timeout, port %0d never accepted a request", $time, port);
        end
    endtask

    task automatic wait_arvalid();
        int waited;
        waited = 0;
        while (!m_arvalid && waited < WAIT_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (!m_arvalid)
        begin
            errors++;
            $display("ERROR at %0t: timeout, m_arvalid never rose", $time);
        end
    endtask

    // Both packetizers empty means the packets sit in the queues
    task automatic wait_ports_idle();
        int waited;
        waited = 0;
        while (!(s0_arready && s1_arready) && waited < WAIT_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (!(s0_arready && s1_arready))
        begin
            errors++;
            $display("ERROR at %0t: timeout, slave ports stayed busy", $time);
        end
    endtask

    task automatic wait_issued(input int n);
        int waited;
        waited = 0;
        while (issued_q.size() < n && waited < WAIT_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (issued_q.size() < n)
        begin
            errors++;
            $display("ERROR at %0t: timeout, %0d of %0d master requests issued",
                     $time, issued_q.size(), n);
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        memsched_pkg::ar_req_t plug;
        memsched_pkg::ar_req_t req_a;
        memsched_pkg::ar_req_t req_b;
        memsched_pkg::ar_req_t found;
        memsched_pkg::ar_req_t reqs [4];
        logic [31:0]           rnd;
        logic                  hs0;
        logic                  hs1;
        int                    n_sent;
        int                    cycles;
        int                    hits;

        errors     = 0;
        seed       = SEED_INIT;
        serial     = '0;
        reset      = 1'b1;
        s0_ar      = '0;
        s0_arvalid = 1'b0;
        s0_rready  = 1'b1;
        s1_ar      = '0;
        s1_arvalid = 1'b0;
        s1_rready  = 1'b1;
        m_arready  = 1'b0;
        m_rvalid   = 1'b0;
        m_rid      = '0;
        m_rdata    = '0;
        m_rlast    = 1'b0;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        repeat (4) next_cycle();
        reset = 1'b0;
        next_cycle();

        // Fixed priority with core 1 outranking core 2 behind a stalled plug request
        cfg_write(3'd2, 32'd1);
        cfg_write(3'd3, 32'd5);
        issued_q.delete();
        plug = make_req(2'd3);
        send_req(0, plug);
        wait_arvalid();
        req_a = make_req(2'd2);
        send_req(0, req_a);
        req_b = make_req(2'd1);
        send_req(1, req_b);
        wait_ports_idle();
        m_arready = 1'b1;
        wait_issued(3);
        if (issued_q.size() >= 3)
        begin
            check_value("m_ar.addr", issued_q[1].addr, req_b.addr);
            check_value("m_ar.id", issued_q[1].id, {1'b1, req_b.id[TAG-1:0]});
            check_value("m_ar.addr", issued_q[2].addr, req_a.addr);
        end

        // EDF with the nearest deadline on queue 3
        cfg_write(3'd2, 32'd60);
        cfg_write(3'd3, 32'd50);
        cfg_write(3'd1, 32'd40);
        cfg_write(3'd4, 32'd8);
        cfg_write(3'd0, 32'd1);
        m_arready = 1'b0;
        issued_q.delete();
        plug = make_req(2'd1);
        send_req(1, plug);
        wait_arvalid();
        for (int c = 0; c < 4; c++)
        begin
            reqs[c] = make_req(2'(c));
            send_req(c % 2, reqs[c]);
        end
        wait_ports_idle();
        m_arready = 1'b1;
        wait_issued(5);
        if (issued_q.size() >= 5)
            check_value("m_ar.addr", issued_q[1].addr, reqs[3].addr);

        // Random traffic with random master back-pressure and responses
        sent_q.delete();
        sent_port.delete();
        issued_q.delete();
        n_sent = 0;
        cycles = 0;
        while ((n_sent < RAND_REQS || s0_arvalid || s1_arvalid) && cycles < RAND_CYCLES)
        begin
            rnd = $random(seed);
            if (!s0_arvalid && n_sent < RAND_REQS && rnd[0])
            begin
                s0_ar      = make_req(rnd[5:4]);
                s0_arvalid = 1'b1;
                n_sent++;
            end
            if (!s1_arvalid && n_sent < RAND_REQS && rnd[1])
            begin
                s1_ar      = make_req(rnd[7:6]);
                s1_arvalid = 1'b1;
                n_sent++;
            end
            m_arready = (rnd[9:8] == 2'b00);
            m_rvalid  = rnd[10];
            s0_rready = rnd[11];
            s1_rready = rnd[12];
            m_rlast   = rnd[13];
            m_rid     = rnd[31:16];
            m_rdata   = {rnd, $random(seed), $random(seed), $random(seed)};
            @(posedge aclk);
            hs0 = s0_arvalid && s0_arready;
            hs1 = s1_arvalid && s1_arready;
            #10;
            if (hs0)
                s0_arvalid = 1'b0;
            if (hs1)
                s1_arvalid = 1'b0;
            cycles++;
        end
        if (s0_arvalid || s1_arvalid)
        begin
            errors++;
            $display("ERROR at %0t: timeout, random requests still pending", $time);
        end
        s0_arvalid = 1'b0;
        s1_arvalid = 1'b0;
        m_rvalid   = 1'b0;
        m_rlast    = 1'b0;
        m_arready  = 1'b1;
        wait_issued(sent_q.size());
        repeat (4) next_cycle();

        check_value("master AR handshakes", issued_q.size(), sent_q.size());
        for (int i = 0; i < sent_q.size(); i++)
        begin
            hits = 0;
            for (int j = 0; j < issued_q.size(); j++)
            begin
                if (issued_q[j].addr == sent_q[i].addr)
                begin
                    hits++;
                    found = issued_q[j];
                end
            end
            check_value($sformatf("copies of m_ar.addr %0h", sent_q[i].addr), hits, 1);
            if (hits == 1)
                check_value("m_ar.id", found.id, {sent_port[i][0], sent_q[i].id[TAG-1:0]});
        end

        $display("error count: testbench %0d, assertions %0d",
                 errors, i_dut.i_sva.fail_count);
        if (errors == 0 && i_dut.i_sva.fail_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
